//--- sources.f
source/mpuPkg.sv
source/ringBufferControl.sv
source/dispatchStage.sv
source/executeStage.sv
source/commitTable.sv
source/mpuCommitTop.sv
verification/mpuCommit_props.sv
verification/mpuCommitTb.sv

//--- Bender.yml
package:
  name: mpu_commit

# RTL in compile order, top level is mpuCommitTop
sources:
  - source/mpuPkg.sv
  - source/ringBufferControl.sv
  - source/dispatchStage.sv
  - source/executeStage.sv
  - source/commitTable.sv
  - source/mpuCommitTop.sv

  # Testbench, top level is mpuCommitTb
  - target: test
    files:
      - verification/mpuCommit_props.sv
      - verification/mpuCommitTb.sv

//--- verification/mpuCommitTb.sv
// Testbench of the MPU commit path
//  - clock, reset and random operation stimulus
//  - reference model of the in-order sequence numbers
//  - comparison process for commits, busy and outstanding count
//  - equal-latency burst and final drain

module mpuCommitTb;
	timeunit 1ns;
	timeprecision 1ps;
	import mpuPkg::*;

	localparam int tableEntries = TABLE_ENTRIES;
	localparam int execSlots = EXEC_SLOTS;
	localparam int WAIT_LIMIT = 200;		// Cycles to wait for busy to drop
	localparam int DRAIN_LIMIT = 1000;		// Cycles to empty the whole path

	logic clock;
	logic reset;
	logic opValid;
	mpuLatency opLatency;
	logic busy;
	logic commitValid;
	mpuSeqNo commitSeq;

	int seed;
	mpuSeqNo expectedSeq;		// Next number the commit must carry
	int acceptedCount;			// Strobes taken by dispatch
	int commitCount;			// Commit pulses seen
	int outstanding;

	mpuCommitTop #(
		.tableEntries(tableEntries),
		.execSlots(execSlots)
	) dut (
		.clock(clock),
		.reset(reset),
		.opValid(opValid),
		.opLatency(opLatency),
		.busy(busy),
		.commitValid(commitValid),
		.commitSeq(commitSeq)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;	// 8 ns period
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Program order, wraps at 256
	function automatic mpuSeqNo nextSeqNo(input mpuSeqNo previous);
		return mpuSeqNo'((int'(previous) + 1) % 256);
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	//////////////////////////////
	// Comparison
	//////////////////////////////

	// Outputs sampled at the rising edge, stable since the previous one
	always @(posedge clock) begin
		if (!reset) begin
			if (commitValid) begin
				commitCount++;
				assert (commitSeq == expectedSeq)
					else failRun($sformatf("mismatch at %0t: commitSeq expected %0d observed %0d",
						$time, expectedSeq, commitSeq));
				expectedSeq = nextSeqNo(expectedSeq);
			end
			// The strobe on opValid now is only taken at this edge
			outstanding = acceptedCount - int'(opValid) - commitCount;
			assert (outstanding >= 0)
				else failRun($sformatf("more commits (%0d) than accepted operations at %0t",
					commitCount, $time));
			assert (outstanding <= tableEntries)
				else failRun($sformatf("%0d operations outstanding, table holds %0d",
					outstanding, tableEntries));
			if (outstanding == tableEntries) begin
				assert (busy)
					else failRun($sformatf("busy low with a full table at %0t", $time));
			end
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// Random strobes, only while the DUT is free
	task automatic randomPhase(input int cycles);
		int draw;
		for (int i = 0; i < cycles; i++) begin
			@(negedge clock);
			draw = $random(seed);
			if (!busy && draw[1:0] != 2'b00) begin
				opValid = 1'b1;
				opLatency = mpuLatency'($random(seed));	// 0 runs as 1
				acceptedCount++;
			end
			else begin
				opValid = 1'b0;
			end
		end
	endtask

	// One operation as soon as busy is low
	task automatic issueOne(input mpuLatency latency);
		int waited;
		waited = 0;
		@(negedge clock);
		opValid = 1'b0;
		while (busy) begin
			waited++;
			if (waited > WAIT_LIMIT) failRun("busy stayed high, operation could not issue");
			@(negedge clock);
		end
		opValid = 1'b1;
		opLatency = latency;
		acceptedCount++;
	endtask

	// Stop issuing and wait for every commit
	task automatic drainAll();
		int waited;
		waited = 0;
		@(negedge clock);
		opValid = 1'b0;
		while (commitCount != acceptedCount) begin
			waited++;
			if (waited > DRAIN_LIMIT) failRun("outstanding operations did not commit in time");
			@(negedge clock);
		end
	endtask

	initial begin
		seed = 32'h7a095927;
		reset = 1'b1;
		opValid = 1'b0;
		opLatency = '0;
		expectedSeq = '0;
		acceptedCount = 0;
		commitCount = 0;
		outstanding = 0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		assert (!busy && !commitValid)
			else failRun("busy or commitValid high after reset");

		randomPhase(400);		// Out-of-order completions
		drainAll();

		for (int i = 0; i < 24; i++) begin
			issueOne(mpuLatency'(4));	// Burst, same latency
		end
		drainAll();

		// Whole path idle again
		assert (!busy)
			else failRun("busy still high with every operation committed");

		$display("All checks passed");
		$finish;
	end

endmodule

//--- verification/mpuCommit_props.sv
// Concurrent checks on the commit table
//  - no write into a full ring
//  - commit pulse only for a committed head
//  - idle flags after reset
//  - completions land on occupied entries

module mpuCommit_props #(
	parameter int entries = mpuPkg::TABLE_ENTRIES
) (
	input logic clock,
	input logic reset,
	input logic issueValid,
	input logic doneValid,
	input mpuPkg::mpuCompletion done,
	input mpuPkg::mpuSlot writeSlot,
	input mpuPkg::mpuSlot headSlot,
	input logic ringFull,
	input logic tableEmpty,
	input logic tableFull,
	input mpuPkg::mpuTableEntry headEntry,		// Entry under the read pointer
	input mpuPkg::commitState headState,
	input logic commitValid,
	input mpuPkg::mpuSeqNo commitSeq
);
	timeunit 1ns;
	timeprecision 1ps;
	import mpuPkg::*;

	logic doneOccupied;		// Completion slot lies in the live window

	always_comb begin : liveWindow
		int offset;
		int used;
		offset = (int'(done.slot) - int'(headSlot) + entries) % entries;
		used = ringFull ? entries : (int'(writeSlot) - int'(headSlot) + entries) % entries;
		doneOccupied = (offset < used);
	end

	assert property (@(posedge clock) disable iff (reset) issueValid |-> !ringFull)
		else $error("commit table written while full");

	// Head held a finished entry, its number leaves and the head moves on
	assert property (@(posedge clock) disable iff (reset)
		commitValid |-> $past(headState == holding && headEntry.committed)
			&& commitSeq == $past(headEntry.seqNo) && headSlot != $past(headSlot))
		else $error("commit pulse without a committed head");

	// Not disabled, it looks at reset itself
	assert property (@(posedge clock) reset |=> !commitValid && !tableFull && tableEmpty)
		else $error("commit table flags not idle after reset");

	assert property (@(posedge clock) disable iff (reset) doneValid |-> doneOccupied)
		else $error("completion for an empty table entry");

endmodule

bind commitTable mpuCommit_props #(
	.entries(entries)
) props (
	.clock(clock),
	.reset(reset),
	.issueValid(issueValid),
	.doneValid(doneValid),
	.done(done),
	.writeSlot(writeSlot),
	.headSlot(headSlot),
	.ringFull(ringFull),
	.tableEmpty(tableEmpty),
	.tableFull(tableFull),
	.headEntry(entryTable[headSlot]),
	.headState(headState),
	.commitValid(commitValid),
	.commitSeq(commitSeq)
);

//--- source/mpuCommitTop.sv
// Top level of the MPU commit path
//  - dispatch, out-of-order execute and in-order commit table
//  - table depth and slot count set here

module mpuCommitTop #(
	parameter int tableEntries = mpuPkg::TABLE_ENTRIES,
	parameter int execSlots = mpuPkg::EXEC_SLOTS
) (
	input logic clock,
	input logic reset,
	input logic opValid,						// Operation strobe
	input mpuPkg::mpuLatency opLatency,
	output logic busy,							// Level, strobes dropped while high
	output logic commitValid,					// In-order commit pulse
	output mpuPkg::mpuSeqNo commitSeq
);
	import mpuPkg::*;

	logic issueValid;
	mpuOp issue;
	mpuSlot freeSlot;
	logic tableFull;
	logic execFull;
	logic doneValid;
	mpuCompletion done;

	dispatchStage dispatch (
		.clock(clock),
		.reset(reset),
		.opValid(opValid),
		.opLatency(opLatency),
		.freeSlot(freeSlot),
		.tableFull(tableFull),
		.execFull(execFull),
		.busy(busy),
		.issueValid(issueValid),
		.issue(issue)
	);

	executeStage #(
		.slots(execSlots)
	) execute (
		.clock(clock),
		.reset(reset),
		.issueValid(issueValid),
		.issue(issue),
		.execFull(execFull),
		.doneValid(doneValid),
		.done(done)
	);

	commitTable #(
		.entries(tableEntries)
	) commit (
		.clock(clock),
		.reset(reset),
		.issueValid(issueValid),
		.issue(issue),
		.doneValid(doneValid),
		.done(done),
		.freeSlot(freeSlot),
		.tableFull(tableFull),
		.commitValid(commitValid),
		.commitSeq(commitSeq)
	);

endmodule

//--- source/commitTable.sv
// Commit table of the MPU
//  - entries of issued operations in a ring
//  - completion marking by table slot
//  - in-order commit of the head with registered outputs
//  - free slot and full flag with look-ahead for dispatch

module commitTable #(
	parameter int entries = mpuPkg::TABLE_ENTRIES
) (
	input logic clock,
	input logic reset,
	input logic issueValid,						// New operation from dispatch
	input mpuPkg::mpuOp issue,
	input logic doneValid,						// Completion from the aggregator
	input mpuPkg::mpuCompletion done,
	output mpuPkg::mpuSlot freeSlot,
	output logic tableFull,
	output logic commitValid,					// One-cycle pulse
	output mpuPkg::mpuSeqNo commitSeq
);
	import mpuPkg::*;

	mpuTableEntry entryTable [entries];
	mpuSlot writeSlot;		// Ring write pointer
	mpuSlot headSlot;		// Oldest outstanding entry
	mpuSlot nextWrite;
	logic writeEnable;
	logic readEnable;
	logic ringFull;
	logic tableEmpty;
	logic headCommit;
	commitState headState;

	//////////////////////////////
	// Head check
	//////////////////////////////

	assign headState = tableEmpty ? empty : holding;
	assign headCommit = (headState == holding) & entryTable[headSlot].committed;

	// Dispatch did the full check
	assign writeEnable = issueValid;
	assign readEnable = headCommit;

	//////////////////////////////
	// Slot handed to dispatch
	//////////////////////////////

	assign nextWrite = (writeSlot == mpuSlot'(entries - 1)) ? '0 : writeSlot + 1'b1;
	assign freeSlot = issueValid ? nextWrite : writeSlot;	// Skip the pending write
	// Last free entry already taken by the issue in flight
	assign tableFull = ringFull | (issueValid & (nextWrite == headSlot));

	//////////////////////////////
	// Entries
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < entries; i++) begin
				entryTable[i] <= '0;
			end
		end
		else begin
			if (doneValid) entryTable[done.slot].committed <= 1'b1;
			if (writeEnable) begin
				entryTable[writeSlot].committed <= 1'b0;	// Never the completing entry
				entryTable[writeSlot].seqNo <= issue.seqNo;
			end
		end
	end

	// Commit outputs
	always_ff @(posedge clock) begin
		if (reset) begin
			commitValid <= 1'b0;
			commitSeq <= '0;
		end
		else begin
			commitValid <= headCommit;
			if (headCommit) commitSeq <= entryTable[headSlot].seqNo;
		end
	end

	ringBufferControl #(
		.entries(entries)
	) ringPointers (
		.clock(clock),
		.reset(reset),
		.writeEnable(writeEnable),
		.readEnable(readEnable),
		.writeAddress(writeSlot),
		.readAddress(headSlot),
		.full(ringFull),
		.empty(tableEmpty)
	);

endmodule

//--- source/executeStage.sv
// Out-of-order execute stage of the MPU
//  - slots holding a table slot and a latency countdown
//  - lowest free slot loads each issue
//  - completion aggregator releasing one ready slot per cycle
//  - execFull with look-ahead for the issue in flight

module executeStage #(
	parameter int slots = mpuPkg::EXEC_SLOTS
) (
	input logic clock,
	input logic reset,
	input logic issueValid,
	input mpuPkg::mpuOp issue,
	output logic execFull,
	output logic doneValid,						// One-cycle pulse
	output mpuPkg::mpuCompletion done
);
	import mpuPkg::*;

	localparam int INDEX_BITS = (slots > 1) ? $clog2(slots) : 1;
	localparam int COUNT_BITS = $clog2(slots + 1);

	// State of one execution slot
	typedef struct packed {
		logic busy;
		mpuSlot tableSlot;		// Entry to mark on completion
		mpuLatency remaining;	// Zero while busy means ready
	} execEntry;

	execEntry slotState [slots];
	logic [slots-1:0] readyMask;
	logic [slots-1:0] freeMask;
	logic [INDEX_BITS-1:0] pickIndex;	// Aggregator choice
	logic [INDEX_BITS-1:0] loadIndex;	// Slot for the incoming issue
	logic [COUNT_BITS-1:0] freeCount;
	logic anyReady;
	mpuLatency loadLatency;

	assign loadLatency = (issue.latency == '0) ? mpuLatency'(1) : issue.latency;

	//////////////////////////////
	// Slot scan
	//////////////////////////////

	always_comb begin
		readyMask = '0;
		freeMask = '0;
		pickIndex = '0;
		loadIndex = '0;
		freeCount = '0;
		for (int i = 0; i < slots; i++) begin
			readyMask[i] = slotState[i].busy & (slotState[i].remaining == '0);
			freeMask[i] = ~slotState[i].busy;
			freeCount = freeCount + COUNT_BITS'(freeMask[i]);
		end
		// Walk down so the lowest index wins
		for (int i = slots - 1; i >= 0; i--) begin
			if (readyMask[i]) pickIndex = INDEX_BITS'(i);
			if (freeMask[i]) loadIndex = INDEX_BITS'(i);
		end
		anyReady = |readyMask;
	end

	// Leave room for the issue already registered in dispatch
	assign execFull = (freeCount == '0) | (issueValid & (freeCount == COUNT_BITS'(1)));

	//////////////////////////////
	// Slots
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < slots; i++) begin
				slotState[i].busy <= 1'b0;
			end
		end
		else begin
			for (int i = 0; i < slots; i++) begin
				if (slotState[i].busy && slotState[i].remaining != '0) begin
					slotState[i].remaining <= slotState[i].remaining - 1'b1;
				end
			end
			if (anyReady) slotState[pickIndex].busy <= 1'b0;	// Released, waiters stay
			if (issueValid) begin
				slotState[loadIndex].busy <= 1'b1;	// Free slot, never the picked one
				slotState[loadIndex].tableSlot <= issue.slot;
				slotState[loadIndex].remaining <= loadLatency;
			end
		end
	end

	//////////////////////////////
	// Completion aggregator
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) doneValid <= 1'b0;
		else doneValid <= anyReady;		// Cycle after selection
	end

	always_ff @(posedge clock) begin
		if (anyReady) done.slot <= slotState[pickIndex].tableSlot;
	end

endmodule

//--- source/dispatchStage.sv
// Dispatch stage of the MPU commit path
//  - accepts operation strobes while not busy
//  - numbers operations in program order
//  - reserves the commit table slot and registers the issue

module dispatchStage (
	input logic clock,
	input logic reset,
	input logic opValid,						// Operation strobe
	input mpuPkg::mpuLatency opLatency,
	input mpuPkg::mpuSlot freeSlot,				// Next table slot to fill
	input logic tableFull,
	input logic execFull,
	output logic busy,							// Strobes ignored while high
	output logic issueValid,
	output mpuPkg::mpuOp issue
);
	import mpuPkg::*;

	mpuSeqNo seqCounter;		// Number of the next accepted operation
	logic accept;

	//////////////////////////////
	// Full check
	//////////////////////////////

	// Both inputs already count the issue still in flight
	assign busy = tableFull | execFull;
	assign accept = opValid & ~busy;

	//////////////////////////////
	// Issue register
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			issueValid <= 1'b0;
		end
		else begin
			issueValid <= accept;	// One cycle after the strobe
		end
	end

	// Payload, only meaningful with issueValid
	always_ff @(posedge clock) begin
		if (accept) begin
			issue.seqNo <= seqCounter;
			issue.slot <= freeSlot;
			issue.latency <= opLatency;
		end
	end

	//////////////////////////////
	// Sequence counter
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			seqCounter <= '0;
		end
		else if (accept) begin
			seqCounter <= seqCounter + 1'b1;	// Wraps at 256
		end
	end

endmodule

//--- source/ringBufferControl.sv
// Pointer controller for a circular table
//  - write and read pointers with wrap at the table depth
//  - occupancy count with full and empty flags

module ringBufferControl #(
	parameter int entries = mpuPkg::TABLE_ENTRIES
) (
	input logic clock,
	input logic reset,
	input logic writeEnable,					// Allocate one entry
	input logic readEnable,						// Release the oldest entry
	output mpuPkg::mpuSlot writeAddress,
	output mpuPkg::mpuSlot readAddress,
	output logic full,
	output logic empty
);
	import mpuPkg::*;

	localparam int COUNT_BITS = $clog2(entries + 1);
	localparam mpuSlot LAST_SLOT = mpuSlot'(entries - 1);

	logic [COUNT_BITS-1:0] count;		// Entries in use
	mpuSlot nextWrite;
	mpuSlot nextRead;

	// Wrap explicitly, depth may be below the slot range
	assign nextWrite = (writeAddress == LAST_SLOT) ? '0 : writeAddress + 1'b1;
	assign nextRead = (readAddress == LAST_SLOT) ? '0 : readAddress + 1'b1;

	assign full = (count == COUNT_BITS'(entries));
	assign empty = (count == '0);

	//////////////////////////////
	// Pointers
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			writeAddress <= '0;
			readAddress <= '0;
		end
		else begin
			if (writeEnable) begin
				writeAddress <= nextWrite;
			end
			if (readEnable) begin
				readAddress <= nextRead;
			end
		end
	end

	//////////////////////////////
	// Occupancy
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end
		else begin
			case ({writeEnable, readEnable})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or none, level unchanged
			endcase
		end
	end

endmodule

//--- source/mpuPkg.sv
// Shared MPU definitions for the in-order commit path
//  - table and execution-slot defaults
//  - slot, sequence and latency widths
//  - operation, completion and table-entry structs
//  - head status enum of the commit table

package mpuPkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	localparam int TABLE_ENTRIES = 8;		// Commit table depth, power of two
	localparam int EXEC_SLOTS = 4;			// Operations in flight in execute

	localparam int SLOT_BITS = $clog2(TABLE_ENTRIES);
	localparam int SEQ_BITS = 8;			// Wraps at 256
	localparam int LATENCY_BITS = 4;

	//////////////////////////////
	// Scalar types
	//////////////////////////////

	typedef logic [SLOT_BITS-1:0] mpuSlot;			// Commit table index
	typedef logic [SEQ_BITS-1:0] mpuSeqNo;			// Program order number
	typedef logic [LATENCY_BITS-1:0] mpuLatency;	// Cycles, 0 runs as 1

	//////////////////////////////
	// Bundles
	//////////////////////////////

	// One dispatched operation
	typedef struct packed {
		mpuSeqNo seqNo;		// Number given at dispatch
		mpuSlot slot;		// Entry reserved in the commit table
		mpuLatency latency;	// Execute time
	} mpuOp;

	// One finished operation, reported by the aggregator
	typedef struct packed {
		mpuSlot slot;
	} mpuCompletion;

	// Commit table entry, occupancy lives in the ring pointers
	typedef struct packed {
		logic committed;	// Execution finished
		mpuSeqNo seqNo;
	} mpuTableEntry;

	// Status of the table head
	typedef enum logic {
		empty,
		holding
	} commitState;

endpackage
